/* idli_alu.sv */
`timescale 1ns/10ps
`default_nettype none

// Serial ALU working on one nibble per clock.
module idli_alu (
  input  var logic             i_ex_gck,

  input  var idli_pkg::ctr_t   i_alu_ctr,
  input  var idli_pkg::ctrl_t  i_alu_ctrl,

  input  var idli_pkg::slice_t i_alu_rf_lhs,
  input  var idli_pkg::slice_t i_alu_rf_rhs,
  input  var idli_pkg::slice_t i_alu_pc,

  output var idli_pkg::slice_t o_alu_out,
  output var logic             o_alu_z,
  output var logic             o_alu_n,
  output var logic             o_alu_c,
  output var logic             o_alu_v
);

  idli_pkg::slice_t lhs;
  idli_pkg::slice_t rhs;
  idli_pkg::slice_t rhs_op;
  idli_pkg::data_t  imm_ext;
  logic [4:0]       sum;
  logic             sub;
  logic             cin;
  logic             carry_q;
  logic             z_acc;
  logic             z_q;

  // Reading R15 gives the PC slice instead of the register file.
  always_comb lhs = i_alu_ctrl.lhs_pc ? i_alu_pc : i_alu_rf_lhs;
  always_comb rhs = i_alu_ctrl.rhs_pc ? i_alu_pc : i_alu_rf_rhs;

  // Subtraction is lhs + ~rhs + 1, with the +1 injected on slice 0.
  always_comb sub    = i_alu_ctrl.alu_op == idli_pkg::ALU_OP_SUB;
  always_comb rhs_op = sub ? ~rhs : rhs;

  // The first slice takes its carry from the opcode and later slices chain
  // from the carry saved at the previous edge.
  always_comb cin = i_alu_ctr == 2'd0 ? sub : carry_q;

  always_comb sum = {1'b0, lhs} + {1'b0, rhs_op} + 5'(cin);

  // Immediates are zero extended and handed out a nibble at a time.
  always_comb imm_ext = idli_pkg::data_t'(i_alu_ctrl.imm);

  always_comb begin
    case (i_alu_ctrl.alu_op)
      idli_pkg::ALU_OP_AND: o_alu_out = lhs & rhs;
      idli_pkg::ALU_OP_OR:  o_alu_out = lhs | rhs;
      idli_pkg::ALU_OP_XOR: o_alu_out = lhs ^ rhs;
      idli_pkg::ALU_OP_IMM: o_alu_out = imm_ext[{i_alu_ctr, 2'b00} +: 4];
      default:              o_alu_out = sum[3:0];
    endcase
  end

  // Carry is kept unconditionally. Only the next slice of the same slot ever
  // uses it, and slice 0 ignores it.
  always_ff @(posedge i_ex_gck) begin
    carry_q <= sum[4];
  end

  // Zero restarts on slice 0 and is and-ed with every later slice.
  always_comb z_acc = i_alu_ctr == 2'd0 ? 1'b1 : z_q;

  always_ff @(posedge i_ex_gck) begin
    z_q <= z_acc && o_alu_out == '0;
  end

  // These flags are only meaningful on slice 3, where they describe the
  // whole word. For a subtract the carry reads as not-borrow.
  always_comb o_alu_z = z_acc && o_alu_out == '0;
  always_comb o_alu_n = o_alu_out[3];
  always_comb o_alu_c = sum[4];

  // Signed overflow: both operands share a sign that the sum does not.
  always_comb o_alu_v = (lhs[3] == rhs_op[3]) && (sum[3] != lhs[3]);

endmodule

`default_nettype wire

/* idli_cond.sv */
`timescale 1ns/10ps
`default_nettype none

// Predicate and conditional-execution state.
module idli_cond (
  input  var logic             i_ex_gck,
  input  var logic             i_ex_rst_n,

  input  var idli_pkg::ctr_t   i_cond_ctr,
  input  var idli_pkg::ctrl_t  i_cond_ctrl,

  input  var logic             i_cond_z,
  input  var logic             i_cond_n,
  input  var logic             i_cond_c,
  input  var logic             i_cond_v,

  output var logic             o_cond_run
);

  logic            pred_q;
  logic            pred_d;
  idli_pkg::cond_t cond_q;
  logic            slot_end;

  // The state is a queue of expected predicate values, one per following
  // instruction, read from bit 0. It only applies while any higher bit is
  // set, so a lone bit 0 means unconditional execution.
  always_comb o_cond_run = cond_q[7:1] == '0 || pred_q == cond_q[0];

  // State only moves on the last cycle of a slot that holds an instruction.
  always_comb slot_end = i_cond_ctr == 2'd3 && i_cond_ctrl.vld;

  // Flags are final on slice 3, which is exactly when they are consumed.
  always_comb begin
    case (i_cond_ctrl.cmp_op)
      idli_pkg::CMP_OP_EQ:  pred_d = i_cond_z;
      idli_pkg::CMP_OP_NE:  pred_d = !i_cond_z;
      idli_pkg::CMP_OP_LT:  pred_d = i_cond_n != i_cond_v;
      idli_pkg::CMP_OP_LTU: pred_d = !i_cond_c;
      idli_pkg::CMP_OP_GE:  pred_d = i_cond_n == i_cond_v;
      default:              pred_d = i_cond_c;
    endcase
  end

  // A skipped compare leaves the old predicate in place.
  always_ff @(posedge i_ex_gck, negedge i_ex_rst_n) begin
    if (!i_ex_rst_n) begin
      pred_q <= 1'b0;
    end else if (slot_end && i_cond_ctrl.cmp && o_cond_run) begin
      pred_q <= pred_d;
    end
  end

  // A taken COND reloads the queue. Any other instruction, including a
  // skipped COND, consumes one entry.
  always_ff @(posedge i_ex_gck, negedge i_ex_rst_n) begin
    if (!i_ex_rst_n) begin
      cond_q <= '0;
    end else if (slot_end) begin
      if (i_cond_ctrl.cond_wr && o_cond_run) begin
        cond_q <= i_cond_ctrl.imm;
      end else begin
        cond_q <= {1'b0, cond_q[7:1]};
      end
    end
  end

  // The run decision must hold for a whole slot, so the predicate may only
  // move across a slot boundary.
  pred_slot_a: assert property (
    @(posedge i_ex_gck) disable iff (!i_ex_rst_n)
    i_cond_ctr != 2'd3 |=> $stable(pred_q)
  );

endmodule

`default_nettype wire

/* idli_decode.sv */
`timescale 1ns/10ps
`default_nettype none

// Slot counter, instruction acceptance and decode.
module idli_decode (
  input  var logic             i_ex_gck,
  input  var logic             i_ex_rst_n,

  input  var idli_pkg::enc_t   i_de_enc,
  input  var logic             i_de_enc_vld,
  output var logic             o_de_enc_acp,

  output var idli_pkg::ctr_t   o_de_ctr,
  output var idli_pkg::ctrl_t  o_de_ctrl
);

  idli_pkg::ctr_t ctr_q;
  idli_pkg::enc_t enc_q;
  logic           vld_q;

  // The counter runs freely. Every fourth cycle closes one slot and opens
  // the next.
  always_ff @(posedge i_ex_gck, negedge i_ex_rst_n) begin
    if (!i_ex_rst_n) begin
      ctr_q <= '0;
    end else begin
      ctr_q <= ctr_q + 2'd1;
    end
  end

  // A new instruction can only be taken on the last cycle of a slot.
  always_comb o_de_enc_acp = ctr_q == 2'd3;

  // Valid marks whether the next slot holds an instruction or a bubble.
  always_ff @(posedge i_ex_gck, negedge i_ex_rst_n) begin
    if (!i_ex_rst_n) begin
      vld_q <= 1'b0;
    end else if (o_de_enc_acp) begin
      vld_q <= i_de_enc_vld;
    end
  end

  // The encoding itself is only meaningful alongside vld_q.
  always_ff @(posedge i_ex_gck) begin
    if (o_de_enc_acp) begin
      enc_q <= i_de_enc;
    end
  end

  // Map the opcode to ALU function, compare kind and destination kind.
  always_comb begin
    o_de_ctrl         = '0;
    o_de_ctrl.vld     = vld_q;
    o_de_ctrl.alu_op  = idli_pkg::ALU_OP_ADD;
    o_de_ctrl.cmp_op  = idli_pkg::CMP_OP_EQ;
    o_de_ctrl.lhs     = enc_q.lhs;
    o_de_ctrl.rhs     = enc_q.rhs;
    o_de_ctrl.dst     = enc_q.dst;
    o_de_ctrl.lhs_pc  = enc_q.lhs == idli_pkg::REG_PC;
    o_de_ctrl.rhs_pc  = enc_q.rhs == idli_pkg::REG_PC;
    o_de_ctrl.imm     = {enc_q.lhs, enc_q.rhs};

    case (enc_q.op)
      idli_pkg::OP_ADD:  o_de_ctrl.alu_op = idli_pkg::ALU_OP_ADD;
      idli_pkg::OP_SUB:  o_de_ctrl.alu_op = idli_pkg::ALU_OP_SUB;
      idli_pkg::OP_AND:  o_de_ctrl.alu_op = idli_pkg::ALU_OP_AND;
      idli_pkg::OP_OR:   o_de_ctrl.alu_op = idli_pkg::ALU_OP_OR;
      idli_pkg::OP_XOR:  o_de_ctrl.alu_op = idli_pkg::ALU_OP_XOR;
      idli_pkg::OP_MOVI: o_de_ctrl.alu_op = idli_pkg::ALU_OP_IMM;
      idli_pkg::OP_COND: o_de_ctrl.alu_op = idli_pkg::ALU_OP_IMM;
      // Compares subtract and only keep the flags.
      default:           o_de_ctrl.alu_op = idli_pkg::ALU_OP_SUB;
    endcase

    case (enc_q.op)
      idli_pkg::OP_ADD, idli_pkg::OP_SUB, idli_pkg::OP_AND,
      idli_pkg::OP_OR, idli_pkg::OP_XOR, idli_pkg::OP_MOVI: begin
        // Writes to R0 are dropped, and writes to R15 redirect.
        o_de_ctrl.wr_pc = enc_q.dst == idli_pkg::REG_PC;
        o_de_ctrl.wr_rf = enc_q.dst != idli_pkg::REG_PC && enc_q.dst != idli_pkg::REG_ZR;
      end
      idli_pkg::OP_EQ:   o_de_ctrl.cmp = 1'b1;
      idli_pkg::OP_NE: begin
        o_de_ctrl.cmp    = 1'b1;
        o_de_ctrl.cmp_op = idli_pkg::CMP_OP_NE;
      end
      idli_pkg::OP_LT: begin
        o_de_ctrl.cmp    = 1'b1;
        o_de_ctrl.cmp_op = idli_pkg::CMP_OP_LT;
      end
      idli_pkg::OP_LTU: begin
        o_de_ctrl.cmp    = 1'b1;
        o_de_ctrl.cmp_op = idli_pkg::CMP_OP_LTU;
      end
      idli_pkg::OP_GE: begin
        o_de_ctrl.cmp    = 1'b1;
        o_de_ctrl.cmp_op = idli_pkg::CMP_OP_GE;
      end
      idli_pkg::OP_GEU: begin
        o_de_ctrl.cmp    = 1'b1;
        o_de_ctrl.cmp_op = idli_pkg::CMP_OP_GEU;
      end
      idli_pkg::OP_COND: o_de_ctrl.cond_wr = 1'b1;
      // Free opcodes still occupy a slot and advance the PC.
      default:           o_de_ctrl.cmp = 1'b0;
    endcase
  end

  always_comb o_de_ctr = ctr_q;

  // Every unit assumes the slices arrive in strict order 0 to 3.
  ctr_step_a: assert property (
    @(posedge i_ex_gck) disable iff (!i_ex_rst_n)
    1'b1 |=> ctr_q == idli_pkg::ctr_t'($past(ctr_q) + 2'd1)
  );

endmodule

`default_nettype wire

/* idli_ex.sv */
`timescale 1ns/10ps
`default_nettype none

// Execute stage top level.
module idli_ex #(
  parameter int NUM_REGS = 16
) (
  input  var logic             i_ex_gck,
  input  var logic             i_ex_rst_n,

  input  var idli_pkg::enc_t   i_ex_enc,
  input  var logic             i_ex_enc_vld,
  output var logic             o_ex_enc_acp,

  output var logic             o_ex_redirect,
  output var idli_pkg::slice_t o_ex_data
);

  idli_pkg::ctr_t   ctr;
  idli_pkg::ctrl_t  ctrl;
  logic             run;
  idli_pkg::slice_t rf_lhs;
  idli_pkg::slice_t rf_rhs;
  idli_pkg::slice_t pc_slice;
  idli_pkg::slice_t alu_out;
  logic             alu_z;
  logic             alu_n;
  logic             alu_c;
  logic             alu_v;

  // Decode owns the slot timing that every other unit follows.
  idli_decode u_decode (
    .i_ex_gck     (i_ex_gck),
    .i_ex_rst_n   (i_ex_rst_n),
    .i_de_enc     (i_ex_enc),
    .i_de_enc_vld (i_ex_enc_vld),
    .o_de_enc_acp (o_ex_enc_acp),
    .o_de_ctr     (ctr),
    .o_de_ctrl    (ctrl)
  );

  idli_rf #(
    .NUM_REGS (NUM_REGS)
  ) u_rf (
    .i_ex_gck  (i_ex_gck),
    .i_rf_ctr  (ctr),
    .i_rf_ctrl (ctrl),
    .i_rf_run  (run),
    .i_rf_data (alu_out),
    .o_rf_lhs  (rf_lhs),
    .o_rf_rhs  (rf_rhs)
  );

  idli_alu u_alu (
    .i_ex_gck     (i_ex_gck),
    .i_alu_ctr    (ctr),
    .i_alu_ctrl   (ctrl),
    .i_alu_rf_lhs (rf_lhs),
    .i_alu_rf_rhs (rf_rhs),
    .i_alu_pc     (pc_slice),
    .o_alu_out    (alu_out),
    .o_alu_z      (alu_z),
    .o_alu_n      (alu_n),
    .o_alu_c      (alu_c),
    .o_alu_v      (alu_v)
  );

  // The PC unit also drives the stage outputs.
  idli_pc u_pc (
    .i_ex_gck      (i_ex_gck),
    .i_ex_rst_n    (i_ex_rst_n),
    .i_pc_ctr      (ctr),
    .i_pc_ctrl     (ctrl),
    .i_pc_run      (run),
    .i_pc_data     (alu_out),
    .o_pc_slice    (pc_slice),
    .o_pc_redirect (o_ex_redirect),
    .o_pc_data     (o_ex_data)
  );

  idli_cond u_cond (
    .i_ex_gck    (i_ex_gck),
    .i_ex_rst_n  (i_ex_rst_n),
    .i_cond_ctr  (ctr),
    .i_cond_ctrl (ctrl),
    .i_cond_z    (alu_z),
    .i_cond_n    (alu_n),
    .i_cond_c    (alu_c),
    .i_cond_v    (alu_v),
    .o_cond_run  (run)
  );

endmodule

`default_nettype wire

/* idli_pc.sv */
`timescale 1ns/10ps
`default_nettype none

// Program counter and redirect outputs.
module idli_pc (
  input  var logic             i_ex_gck,
  input  var logic             i_ex_rst_n,

  input  var idli_pkg::ctr_t   i_pc_ctr,
  input  var idli_pkg::ctrl_t  i_pc_ctrl,
  input  var logic             i_pc_run,

  input  var idli_pkg::slice_t i_pc_data,

  output var idli_pkg::slice_t o_pc_slice,
  output var logic             o_pc_redirect,
  output var idli_pkg::slice_t o_pc_data
);

  // The PC holds the address of the instruction currently in the slot.
  idli_pkg::data_t pc_q;
  logic [11:0]     res_q;

  always_comb o_pc_slice = pc_q[{i_pc_ctr, 2'b00} +: 4];

  // A redirect covers the whole slot of a taken write to R15.
  always_comb o_pc_redirect = i_pc_ctrl.vld && i_pc_ctrl.wr_pc && i_pc_run;

  // The result slice goes out every cycle. It is the target on redirects.
  always_comb o_pc_data = i_pc_data;

  // Collect the low three result slices. Slice 3 arrives with the load.
  always_ff @(posedge i_ex_gck) begin
    case (i_pc_ctr)
      2'd0:    res_q[3:0]  <= i_pc_data;
      2'd1:    res_q[7:4]  <= i_pc_data;
      2'd2:    res_q[11:8] <= i_pc_data;
      default: res_q       <= res_q;
    endcase
  end

  // At the end of the slot either jump to the result or step past this
  // instruction. Bubbles leave the PC where it is.
  always_ff @(posedge i_ex_gck, negedge i_ex_rst_n) begin
    if (!i_ex_rst_n) begin
      pc_q <= '0;
    end else if (i_pc_ctr == 2'd3) begin
      if (o_pc_redirect) begin
        pc_q <= {i_pc_data, res_q};
      end else if (i_pc_ctrl.vld) begin
        pc_q <= pc_q + 16'd1;
      end
    end
  end

endmodule

`default_nettype wire

/* idli_pkg.sv */
`default_nettype none

// Shared widths, instruction layout and decoded control for the execute stage.
package idli_pkg;

  // A data slice is the unit of work for one clock of the serial datapath.
  typedef logic [3:0]  slice_t;
  typedef logic [15:0] data_t;
  typedef logic [3:0]  reg_t;

  // The slot counter also names the slice being worked on.
  typedef logic [1:0]  ctr_t;

  // Conditional execution state and immediates.
  typedef logic [7:0]  cond_t;
  typedef logic [7:0]  imm_t;

  // Fixed registers. R0 always reads as zero and R15 aliases the PC.
  localparam reg_t REG_ZR = 4'd0;
  localparam reg_t REG_PC = 4'd15;

  // Opcodes. The values 6, 7 and 15 are left free and execute as no-ops.
  typedef enum logic [3:0] {
    OP_ADD  = 4'd0,
    OP_SUB  = 4'd1,
    OP_AND  = 4'd2,
    OP_OR   = 4'd3,
    OP_XOR  = 4'd4,
    OP_MOVI = 4'd5,
    OP_EQ   = 4'd8,
    OP_NE   = 4'd9,
    OP_LT   = 4'd10,
    OP_LTU  = 4'd11,
    OP_GE   = 4'd12,
    OP_GEU  = 4'd13,
    OP_COND = 4'd14
  } op_t;

  // Function performed by the serial ALU.
  typedef enum logic [2:0] {
    ALU_OP_ADD,
    ALU_OP_SUB,
    ALU_OP_AND,
    ALU_OP_OR,
    ALU_OP_XOR,
    ALU_OP_IMM
  } alu_op_t;

  // How the final ALU flags turn into a predicate value.
  typedef enum logic [2:0] {
    CMP_OP_EQ,
    CMP_OP_NE,
    CMP_OP_LT,
    CMP_OP_LTU,
    CMP_OP_GE,
    CMP_OP_GEU
  } cmp_op_t;

  // Raw instruction. For MOVI and COND the lhs and rhs fields form the
  // immediate, with lhs as the upper nibble.
  typedef struct packed {
    op_t  op;
    reg_t dst;
    reg_t lhs;
    reg_t rhs;
  } enc_t;

  // Decoded control, held constant for the four cycles of a slot.
  typedef struct packed {
    logic    vld;
    alu_op_t alu_op;
    logic    lhs_pc;
    logic    rhs_pc;
    reg_t    lhs;
    reg_t    rhs;
    reg_t    dst;
    logic    wr_rf;
    logic    wr_pc;
    logic    cmp;
    cmp_op_t cmp_op;
    logic    cond_wr;
    imm_t    imm;
  } ctrl_t;

endpackage

`default_nettype wire

/* idli_rf.sv */
`timescale 1ns/10ps
`default_nettype none

// Register file read and written one slice per clock.
module idli_rf #(
  parameter int NUM_REGS = 16
) (
  input  var logic             i_ex_gck,

  input  var idli_pkg::ctr_t   i_rf_ctr,
  input  var idli_pkg::ctrl_t  i_rf_ctrl,
  input  var logic             i_rf_run,

  input  var idli_pkg::slice_t i_rf_data,
  output var idli_pkg::slice_t o_rf_lhs,
  output var idli_pkg::slice_t o_rf_rhs
);

  idli_pkg::data_t regs_q [NUM_REGS];
  logic            wr_en;

  // R0 reads zero, and so does any index past the end of a smaller file.
  always_comb begin
    o_rf_lhs = '0;
    if (i_rf_ctrl.lhs != idli_pkg::REG_ZR && 32'(i_rf_ctrl.lhs) < NUM_REGS) begin
      o_rf_lhs = regs_q[i_rf_ctrl.lhs][{i_rf_ctr, 2'b00} +: 4];
    end
  end

  always_comb begin
    o_rf_rhs = '0;
    if (i_rf_ctrl.rhs != idli_pkg::REG_ZR && 32'(i_rf_ctrl.rhs) < NUM_REGS) begin
      o_rf_rhs = regs_q[i_rf_ctrl.rhs][{i_rf_ctr, 2'b00} +: 4];
    end
  end

  // Only instructions that survive the condition check update state.
  always_comb wr_en = i_rf_ctrl.vld && i_rf_ctrl.wr_rf && i_rf_run;

  // Slice i lands at the end of the cycle where the counter is i, so a read
  // of the same register later in the slot still sees the old upper bits.
  always_ff @(posedge i_ex_gck) begin
    if (wr_en) begin
      regs_q[i_rf_ctrl.dst][{i_rf_ctr, 2'b00} +: 4] <= i_rf_data;
    end
  end

  // R15 lives in the PC unit, so decode must never route its writes here.
  no_pc_write_a: assert property (
    @(posedge i_ex_gck)
    (i_rf_ctrl.vld && i_rf_ctrl.wr_rf) |-> i_rf_ctrl.dst != idli_pkg::REG_PC
  );

endmodule

`default_nettype wire

/* idli_tb.sv */
`timescale 1ns/10ps
`default_nettype none

// Random-stimulus testbench for the execute stage, checked against a reference model.
module idli_tb;

  localparam int NUM_INIT    = 14;
  localparam int NUM_RANDOM  = 600;
  localparam int ACP_TIMEOUT = 16;

  logic             gck;
  logic             rst_n;
  idli_pkg::enc_t   enc;
  logic             enc_vld;
  logic             enc_acp;
  logic             redirect;
  idli_pkg::slice_t data;

  // Architectural state as the model sees it between slots.
  idli_pkg::data_t  model_regs [16];
  idli_pkg::data_t  model_pc;
  logic             model_pred;
  idli_pkg::cond_t  model_cond;

  logic [31:0]      rng;
  int               acp_errors;
  int               redirect_errors;
  int               data_errors;
  int               timeout_errors;

  idli_ex #(
    .NUM_REGS (16)
  ) i_idli_ex (
    .i_ex_gck      (gck),
    .i_ex_rst_n    (rst_n),
    .i_ex_enc      (enc),
    .i_ex_enc_vld  (enc_vld),
    .o_ex_enc_acp  (enc_acp),
    .o_ex_redirect (redirect),
    .o_ex_data     (data)
  );

  always #4 gck = ~gck;

  function automatic logic [31:0] xorshift(input logic [31:0] state);
    logic [31:0] x;
    x = state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // R0 reads zero and R15 reads the address of the instruction itself.
  function automatic idli_pkg::data_t read_operand(input idli_pkg::reg_t r);
    idli_pkg::data_t val;
    if (r == idli_pkg::REG_ZR) begin
      val = '0;
    end else if (r == idli_pkg::REG_PC) begin
      val = model_pc;
    end else begin
      val = model_regs[r];
    end
    return val;
  endfunction

  task automatic pick_instruction(input int idx, output idli_pkg::enc_t e, output logic v);
    logic [31:0] r;
    rng = xorshift(rng);
    r   = rng;
    e   = idli_pkg::enc_t'(r[15:0]);
    // Roughly three slots in four carry an instruction.
    v   = r[31:30] != 2'd0;
    if (idx < NUM_INIT) begin
      // Load R1 to R14 with known bytes before anything reads them.
      e.op  = idli_pkg::OP_MOVI;
      e.dst = idli_pkg::reg_t'(idx + 1);
      v     = 1'b1;
    end else if (r[21:20] == 2'd0) begin
      // Steer a share of the results at R15 so they become visible as redirects.
      e.dst = idli_pkg::REG_PC;
    end
  endtask

  // Executes one slot on the model and returns what the DUT should show for it.
  task automatic apply_model(input idli_pkg::enc_t e, input logic v, output logic exp_redir,
                             output idli_pkg::data_t exp_word, output logic chk_word);
    idli_pkg::data_t a;
    idli_pkg::data_t b;
    idli_pkg::data_t res;
    idli_pkg::imm_t  imm;
    logic            run;
    logic            writes;
    logic            is_cmp;
    logic            pred;
    a      = read_operand(e.lhs);
    b      = read_operand(e.rhs);
    imm    = {e.lhs, e.rhs};
    run    = model_cond[7:1] == 7'd0 || model_pred == model_cond[0];
    writes = e.op <= 4'd5;
    is_cmp = e.op >= 4'd8 && e.op <= 4'd13;
    res    = '0;
    pred   = model_pred;
    case (e.op)
      idli_pkg::OP_ADD:  res  = a + b;
      idli_pkg::OP_SUB:  res  = a - b;
      idli_pkg::OP_AND:  res  = a & b;
      idli_pkg::OP_OR:   res  = a | b;
      idli_pkg::OP_XOR:  res  = a ^ b;
      idli_pkg::OP_MOVI: res  = idli_pkg::data_t'(imm);
      idli_pkg::OP_EQ:   pred = a == b;
      idli_pkg::OP_NE:   pred = a != b;
      idli_pkg::OP_LT:   pred = $signed(a) < $signed(b);
      idli_pkg::OP_LTU:  pred = a < b;
      idli_pkg::OP_GE:   pred = $signed(a) >= $signed(b);
      idli_pkg::OP_GEU:  pred = a >= b;
      default:           pred = model_pred;
    endcase
    // A compare is a subtraction whose word still appears on the data output.
    if (is_cmp) begin
      res = a - b;
    end
    exp_redir = v && run && writes && e.dst == idli_pkg::REG_PC;
    exp_word  = res;
    chk_word  = v && (writes || is_cmp);
    if (v) begin
      if (run && writes && e.dst != idli_pkg::REG_PC && e.dst != idli_pkg::REG_ZR) begin
        model_regs[e.dst] = res;
      end
      if (run && is_cmp) begin
        model_pred = pred;
      end
      // Each valid instruction consumes one condition bit unless a taken COND reloads it.
      if (run && e.op == idli_pkg::OP_COND) begin
        model_cond = imm;
      end else begin
        model_cond = model_cond >> 1;
      end
      if (exp_redir) begin
        model_pc = res;
      end else begin
        model_pc = model_pc + 16'd1;
      end
    end
  endtask

  // Samples the four cycles of a slot at the falling edge, where outputs are settled.
  task automatic check_slot(input logic exp_redir, input idli_pkg::data_t exp_word,
                            input logic chk_word);
    idli_pkg::data_t word;
    logic            exp_acp;
    word = '0;
    for (int k = 0; k < 4; k++) begin
      @(negedge gck);
      exp_acp = k == 3;
      assert (enc_acp == exp_acp) else begin
        acp_errors++;
        $display("error: o_ex_enc_acp 0x%0h, expected 0x%0h at %0t", enc_acp, exp_acp, $time);
      end
      assert (redirect == exp_redir) else begin
        redirect_errors++;
        $display("error: o_ex_redirect 0x%0h, expected 0x%0h at %0t", redirect, exp_redir,
                 $time);
      end
      word[4*k +: 4] = data;
    end
    if (chk_word) begin
      assert (word == exp_word) else begin
        data_errors++;
        $display("error: o_ex_data word 0x%04h, expected 0x%04h at %0t", word, exp_word,
                 $time);
      end
    end
  endtask

  // Waits for the next acceptance cycle and reports whether it came in time.
  task automatic wait_for_accept(output logic seen);
    int cnt;
    cnt = 0;
    while (!enc_acp && cnt < ACP_TIMEOUT) begin
      @(negedge gck);
      cnt++;
    end
    seen = enc_acp;
    if (!seen) begin
      timeout_errors++;
      $display("timeout: the DUT stopped accepting instructions at %0t", $time);
    end
  endtask

  initial begin
    idli_pkg::enc_t  next_enc;
    logic            next_vld;
    logic            exp_redir;
    idli_pkg::data_t exp_word;
    logic            chk_word;
    logic            acp_seen;
    gck             = 1'b0;
    rst_n           = 1'b0;
    enc             = '0;
    enc_vld         = 1'b0;
    rng             = 32'he121;
    acp_errors      = 0;
    redirect_errors = 0;
    data_errors     = 0;
    timeout_errors  = 0;
    model_pc        = '0;
    model_pred      = 1'b0;
    model_cond      = '0;
    for (int i = 0; i < 16; i++) begin
      model_regs[i] = '0;
    end

    // No redirect may appear while reset is held.
    for (int i = 0; i < 8; i++) begin
      @(negedge gck);
      assert (!redirect) else begin
        redirect_errors++;
        $display("error: o_ex_redirect 0x%0h, expected 0x0 during reset", redirect);
      end
      @(posedge gck);
    end
    rst_n <= 1'b1;
    pick_instruction(0, next_enc, next_vld);
    enc     <= next_enc;
    enc_vld <= next_vld;

    // The slot after reset is empty and ends with the first acceptance.
    check_slot(1'b0, '0, 1'b0);

    for (int n = 0; n < NUM_INIT + NUM_RANDOM; n++) begin
      wait_for_accept(acp_seen);
      if (!acp_seen) begin
        break;
      end
      @(posedge gck);
      apply_model(next_enc, next_vld, exp_redir, exp_word, chk_word);
      pick_instruction(n + 1, next_enc, next_vld);
      enc     <= next_enc;
      enc_vld <= next_vld;
      check_slot(exp_redir, exp_word, chk_word);
    end

    $display("errors: acp %0d, redirect %0d, data %0d, timeout %0d", acp_errors,
             redirect_errors, data_errors, timeout_errors);
    if (acp_errors + redirect_errors + data_errors + timeout_errors == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* project.f */
idli_pkg.sv
idli_decode.sv
idli_rf.sv
idli_alu.sv
idli_pc.sv
idli_cond.sv
idli_ex.sv
idli_tb.sv
